// ==== mmio_enclave_patterns.txt ====
# op name addr data expected, all hex; W write, R read, M mtime write then read, G read at least
# S/E/T wait for soft/external/timer irq vector, C config write and strobe vector, B stalled write
R cmp0_reset 02000 0 ffffffffffffffff
R cmp1_reset 02008 0 ffffffffffffffff
R cmp2_reset 02010 0 ffffffffffffffff
R cmp3_reset 02018 0 ffffffffffffffff
M mtime_set 03000 1000 1000
G mtime_later 03000 0 1000
G unmapped 05000 0 1000
W mipi2_set 01010 1 0
R mipi2_read 01010 0 1
S soft2_high 0 0 4
W mipi2_clr 01010 0 1
S soft2_low 0 0 0
W plic0_set 04000 1 0
R plic0_read 04000 0 1
E ext0_high 0 0 1
W plic0_clr 04000 0 1
E ext0_low 0 0 0
B stall_mipi1 01008 1 0
W mipi1_taken 01008 1 0
R mipi1_read 01008 0 1
W mipi1_clr 01008 0 1
M mtime_low 03000 0 0
W cmp1_set 02008 40 ffffffffffffffff
T timer_low 0 0 0
T timer1_high 0 0 2
C cfg_core3 00000 0003abcd12345678 8
C cfg_bcast 00000 00ff00420000beef f
C cfg_none 00000 0009111122223333 0

// ==== mmio_enclave.f ====
mmio_pkg.sv
mmio_dev_if.sv
mmio_cmd_decode.sv
clint_timer.sv
clint_irq_bits.sv
cfg_link_fanout.sv
mmio_enclave.sv
mmio_enclave_tb.sv

// ==== Makefile ====
# Verilator build and run for the MMIO enclave testbench
VERILATOR ?= verilator
TOP ?= mmio_enclave_tb
FILELIST ?= mmio_enclave.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== mmio_enclave_tb.sv ====
// Testbench for the MMIO enclave; replays mmio_enclave_patterns.txt against the DUT and checks it
module mmio_enclave_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_core = 4;
   localparam int timeout = 200;

   logic clk_i = 1'b0;
   logic rst_i;
   logic cmd_v_i;
   logic cmd_wr_i;
   mmio_pkg::mmio_addr_t cmd_addr_i;
   mmio_pkg::dword_t cmd_data_i;
   logic cmd_yumi_o;
   logic resp_v_o;
   mmio_pkg::dword_t resp_data_o;
   logic resp_ready_i;
   logic [num_core-1:0] soft_irq_o;
   logic [num_core-1:0] timer_irq_o;
   logic [num_core-1:0] external_irq_o;
   logic [num_core-1:0] cfg_w_v_o;
   mmio_pkg::cfg_addr_t [num_core-1:0] cfg_addr_o;
   mmio_pkg::cfg_data_t [num_core-1:0] cfg_data_o;

   int pass_count = 0;
   int fail_count = 0;
   bit test_ok = 1'b1;

   always #20 clk_i = ~clk_i;

   mmio_enclave uut
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .cmd_v_i(cmd_v_i),
      .cmd_wr_i(cmd_wr_i),
      .cmd_addr_i(cmd_addr_i),
      .cmd_data_i(cmd_data_i),
      .cmd_yumi_o(cmd_yumi_o),
      .resp_v_o(resp_v_o),
      .resp_data_o(resp_data_o),
      .resp_ready_i(resp_ready_i),
      .soft_irq_o(soft_irq_o),
      .timer_irq_o(timer_irq_o),
      .external_irq_o(external_irq_o),
      .cfg_w_v_o(cfg_w_v_o),
      .cfg_addr_o(cfg_addr_o),
      .cfg_data_o(cfg_data_o)
   );

   task automatic check_val(input string name, input logic [63:0] want, input logic [63:0] got);
      if (got !== want)
      begin
         $display("Error %s expected %h actual %h", name, want, got);
         test_ok = 1'b0;
      end
   endtask

   task automatic report(input string name);
      if (test_ok)
      begin
         pass_count++;
         $display("PASS %s", name);
      end
      else
      begin
         fail_count++;
         $display("FAIL %s", name);
      end
      test_ok = 1'b1;
   endtask

   task automatic drive_cmd(input logic wr, input mmio_pkg::mmio_addr_t addr,
                            input mmio_pkg::dword_t data);
      cmd_v_i = 1'b1;
      cmd_wr_i = wr;
      cmd_addr_i = addr;
      cmd_data_i = data;
   endtask

   // Held command must not be taken while resp_ready_i is low
   task automatic hold_stalled(input int cycles);
      resp_ready_i = 1'b0;
      repeat (cycles)
      begin
         @(negedge clk_i);
         if (cmd_yumi_o || resp_v_o)
         begin
            $display("Error handshake raised while resp_ready_i was low");
            test_ok = 1'b0;
         end
         @(posedge clk_i);
         #2;
      end
   endtask

   task automatic run_cmd(input logic wr, input mmio_pkg::mmio_addr_t addr,
                          input mmio_pkg::dword_t data, input int stall,
                          output mmio_pkg::dword_t rdata);
      int n;
      n = 0;
      drive_cmd(wr, addr, data);
      hold_stalled(stall);
      resp_ready_i = 1'b1;
      @(negedge clk_i);
      while (!(cmd_yumi_o && resp_v_o) && n < timeout)
      begin
         @(negedge clk_i);
         n++;
      end
      if (n >= timeout)
      begin
         $display("Error command was not taken within %0d cycles", timeout);
         test_ok = 1'b0;
      end
      rdata = resp_data_o;
      @(posedge clk_i);
      #2;
      cmd_v_i = 1'b0;
      cmd_wr_i = 1'b0;
   endtask

   function automatic logic [num_core-1:0] pick_vec(input string kind);
      case (kind)
         "S": return soft_irq_o;
         "E": return external_irq_o;
         "T": return timer_irq_o;
         default: return cfg_w_v_o;
      endcase
   endfunction

   task automatic wait_vec(input string kind, input logic [num_core-1:0] want,
                           output logic [num_core-1:0] got);
      int n;
      n = 0;
      @(negedge clk_i);
      got = pick_vec(kind);
      while (got !== want && n < timeout)
      begin
         @(negedge clk_i);
         got = pick_vec(kind);
         n++;
      end
      @(posedge clk_i);
      #2;
   endtask

   // Strobe vector, then payload per strobed core, then a one-cycle pulse
   task automatic cfg_check(input string name, input mmio_pkg::dword_t payload,
                            input mmio_pkg::dword_t want);
      int n;
      n = 0;
      @(negedge clk_i);
      while (cfg_w_v_o == '0 && n < timeout)
      begin
         @(negedge clk_i);
         n++;
      end
      check_val(name, want, 64'(cfg_w_v_o));
      for (int i = 0; i < num_core; i++)
      begin
         if (cfg_w_v_o[i])
         begin
            check_val({name, "_addr"}, 64'(payload[47:32]), 64'(cfg_addr_o[i]));
            check_val({name, "_data"}, 64'(payload[31:0]), 64'(cfg_data_o[i]));
         end
      end
      @(negedge clk_i);
      if (cfg_w_v_o != '0)
      begin
         $display("Error %s config strobe lasted more than one cycle", name);
         test_ok = 1'b0;
      end
      @(posedge clk_i);
      #2;
   endtask

   initial
   begin
      int fd;
      int n;
      int stall;
      string line;
      string op;
      string name;
      mmio_pkg::mmio_addr_t addr;
      mmio_pkg::dword_t data;
      mmio_pkg::dword_t expv;
      mmio_pkg::dword_t rdata;
      logic [num_core-1:0] vec;

      void'($urandom(32'hb203_7911));
      rst_i = 1'b1;
      cmd_v_i = 1'b0;
      cmd_wr_i = 1'b0;
      cmd_addr_i = '0;
      cmd_data_i = '0;
      resp_ready_i = 1'b1;
      repeat (10) @(posedge clk_i);
      #2;
      rst_i = 1'b0;

      check_val("reset_outputs", 64'd0,
                64'({soft_irq_o, timer_irq_o, external_irq_o, cfg_w_v_o}));
      report("reset_outputs");

      fd = $fopen("mmio_enclave_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Error pattern file could not be opened");
         fail_count++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
               continue;
            n = $sscanf(line, "%s %s %h %h %h", op, name, addr, data, expv);
            if (n != 5)
            begin
               $display("Error malformed pattern line: %s", line);
               test_ok = 1'b0;
               report("pattern_line");
               continue;
            end
            stall = $urandom_range(0, 3);
            case (op)
               "W", "R":
               begin
                  run_cmd(op == "W", addr, data, stall, rdata);
                  check_val(name, expv, rdata);
               end
               // Read issued in the cycle right after the write
               "M":
               begin
                  run_cmd(1'b1, addr, data, stall, rdata);
                  run_cmd(1'b0, addr, '0, 0, rdata);
                  check_val(name, expv, rdata);
               end
               "G":
               begin
                  run_cmd(1'b0, addr, '0, stall, rdata);
                  if (rdata < expv)
                  begin
                     $display("Error %s expected at least %h actual %h", name, expv, rdata);
                     test_ok = 1'b0;
                  end
               end
               "S", "E", "T":
               begin
                  wait_vec(op, expv[num_core-1:0], vec);
                  check_val(name, expv, 64'(vec));
               end
               "C":
               begin
                  run_cmd(1'b1, addr, data, stall, rdata);
                  check_val({name, "_resp"}, 64'd0, rdata);
                  cfg_check(name, data, expv);
               end
               "B":
               begin
                  drive_cmd(1'b1, addr, data);
                  hold_stalled(8);
                  run_cmd(1'b0, addr, '0, 0, rdata);
                  check_val(name, expv, rdata);
               end
               default:
               begin
                  $display("Error unknown operation %s in pattern file", op);
                  test_ok = 1'b0;
               end
            endcase
            report(name);
         end
         $fclose(fd);
      end

      $display("Tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0 && pass_count > 1)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== mmio_enclave.sv ====
// RTL top level of the MMIO enclave that ties the command port and response mux to four devices
module mmio_enclave
#(
   parameter int num_core = 4,
   parameter int irq_pipe_depth = 4,
   parameter int cfg_pipe_depth = 4
)
(
   input logic clk_i,
   input logic rst_i,

   input logic cmd_v_i,
   input logic cmd_wr_i,
   input mmio_pkg::mmio_addr_t cmd_addr_i,
   input mmio_pkg::dword_t cmd_data_i,
   output logic cmd_yumi_o,

   output logic resp_v_o,
   output mmio_pkg::dword_t resp_data_o,
   input logic resp_ready_i,

   output logic [num_core-1:0] soft_irq_o,
   output logic [num_core-1:0] timer_irq_o,
   output logic [num_core-1:0] external_irq_o,

   output logic [num_core-1:0] cfg_w_v_o,
   output mmio_pkg::cfg_addr_t [num_core-1:0] cfg_addr_o,
   output mmio_pkg::cfg_data_t [num_core-1:0] cfg_data_o
);

   logic take;
   mmio_pkg::region_t rd_region;
   mmio_pkg::dword_t mtime;
   mmio_pkg::dword_t mtimecmp_rd;
   logic mipi_rd;
   logic plic_rd;

   mmio_dev_if #(.num_core(num_core)) dev_if ();

   mmio_cmd_decode #(.num_core(num_core)) u_decode
   (
      .cmd_v_i(cmd_v_i),
      .cmd_wr_i(cmd_wr_i),
      .resp_ready_i(resp_ready_i),
      .cmd_addr_i(cmd_addr_i),
      .cmd_data_i(cmd_data_i),
      .take_o(take),
      .dev(dev_if.decode),
      .rd_region_o(rd_region)
   );

   clint_timer #(.num_core(num_core), .irq_pipe_depth(irq_pipe_depth)) u_timer
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .dev(dev_if.dev),
      .mtime_o(mtime),
      .mtimecmp_rd_o(mtimecmp_rd),
      .timer_irq_o(timer_irq_o)
   );

   clint_irq_bits #(.num_core(num_core), .irq_pipe_depth(irq_pipe_depth)) u_irq_bits
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .dev(dev_if.dev),
      .mipi_rd_o(mipi_rd),
      .plic_rd_o(plic_rd),
      .soft_irq_o(soft_irq_o),
      .external_irq_o(external_irq_o)
   );

   cfg_link_fanout #(.num_core(num_core), .cfg_pipe_depth(cfg_pipe_depth)) u_cfg
   (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .dev(dev_if.dev),
      .cfg_w_v_o(cfg_w_v_o),
      .cfg_addr_o(cfg_addr_o),
      .cfg_data_o(cfg_data_o)
   );

   // Response goes out in the same cycle the command is taken
   assign cmd_yumi_o = take;
   assign resp_v_o = take;

   always_comb
   begin
      case (rd_region)
         mmio_pkg::region_plic: resp_data_o = mmio_pkg::dword_t'(plic_rd);
         mmio_pkg::region_mipi: resp_data_o = mmio_pkg::dword_t'(mipi_rd);
         mmio_pkg::region_mtimecmp: resp_data_o = mtimecmp_rd;
         mmio_pkg::region_cfg: resp_data_o = '0;
         // mtime region and unmapped addresses
         default: resp_data_o = mtime;
      endcase
   end

endmodule

// ==== cfg_link_fanout.sv ====
// Config link writes fanned out to one core or broadcast, through a delay pipe per core
module cfg_link_fanout
#(
   parameter int num_core = 4,
   parameter int cfg_pipe_depth = 4
)
(
   input logic clk_i,
   input logic rst_i,
   mmio_dev_if.dev dev,
   output logic [num_core-1:0] cfg_w_v_o,
   output mmio_pkg::cfg_addr_t [num_core-1:0] cfg_addr_o,
   output mmio_pkg::cfg_data_t [num_core-1:0] cfg_data_o
);

   mmio_pkg::cfg_core_t target;
   mmio_pkg::cfg_addr_t addr_in;
   mmio_pkg::cfg_data_t data_in;
   logic [num_core-1:0] strobe;
   logic [cfg_pipe_depth-1:0][num_core-1:0] v_pipe;
   mmio_pkg::cfg_addr_t [cfg_pipe_depth-1:0][num_core-1:0] addr_pipe;
   mmio_pkg::cfg_data_t [cfg_pipe_depth-1:0][num_core-1:0] data_pipe;

   assign target = dev.wdata[mmio_pkg::cfg_core_lsb +: mmio_pkg::cfg_core_width];
   assign addr_in = dev.wdata[mmio_pkg::cfg_addr_lsb +: mmio_pkg::cfg_addr_width];
   assign data_in = dev.wdata[mmio_pkg::cfg_data_lsb +: mmio_pkg::cfg_data_width];

   // Out-of-range targets match no core under the full-width compare
   always_comb
   begin
      for (int i = 0; i < num_core; i++)
         strobe[i] = dev.wr_v && dev.cfg_sel &&
                     ((target == mmio_pkg::cfg_broadcast) ||
                      (target == mmio_pkg::cfg_core_t'(i)));
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         v_pipe <= '0;
      else
      begin
         v_pipe[0] <= strobe;
         for (int s = 1; s < cfg_pipe_depth; s++)
            v_pipe[s] <= v_pipe[s-1];
      end
   end

   // Payload follows the strobe stage for stage
   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < num_core; i++)
      begin
         addr_pipe[0][i] <= addr_in;
         data_pipe[0][i] <= data_in;
      end
      for (int s = 1; s < cfg_pipe_depth; s++)
      begin
         addr_pipe[s] <= addr_pipe[s-1];
         data_pipe[s] <= data_pipe[s-1];
      end
   end

   assign cfg_w_v_o = v_pipe[cfg_pipe_depth-1];
   assign cfg_addr_o = addr_pipe[cfg_pipe_depth-1];
   assign cfg_data_o = data_pipe[cfg_pipe_depth-1];

endmodule

// ==== clint_irq_bits.sv ====
// Per-core software and external interrupt bits, delayed out to the cores and readable back
module clint_irq_bits
#(
   parameter int num_core = 4,
   parameter int irq_pipe_depth = 4
)
(
   input logic clk_i,
   input logic rst_i,
   mmio_dev_if.dev dev,
   output logic mipi_rd_o,
   output logic plic_rd_o,
   output logic [num_core-1:0] soft_irq_o,
   output logic [num_core-1:0] external_irq_o
);

   logic [num_core-1:0] mipi_r;
   logic [num_core-1:0] plic_r;

   // Upper half plic, lower half mipi
   logic [irq_pipe_depth-1:0][2*num_core-1:0] irq_pipe;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         mipi_r <= '0;
         plic_r <= '0;
      end
      else
      begin
         for (int i = 0; i < num_core; i++)
         begin
            if (dev.wr_v && dev.mipi_sel[i])
               mipi_r[i] <= dev.wdata[0];
            if (dev.wr_v && dev.plic_sel[i])
               plic_r[i] <= dev.wdata[0];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         irq_pipe <= '0;
      else
      begin
         irq_pipe[0] <= {plic_r, mipi_r};
         for (int s = 1; s < irq_pipe_depth; s++)
            irq_pipe[s] <= irq_pipe[s-1];
      end
   end

   assign {external_irq_o, soft_irq_o} = irq_pipe[irq_pipe_depth-1];

   // Selects are one-hot so an OR picks the addressed bit
   assign mipi_rd_o = |(mipi_r & dev.mipi_sel);
   assign plic_rd_o = |(plic_r & dev.plic_sel);

endmodule

// ==== clint_timer.sv ====
// Machine timer with per-core compare registers; drives delayed timer interrupts to the cores
module clint_timer
#(
   parameter int num_core = 4,
   parameter int irq_pipe_depth = 4
)
(
   input logic clk_i,
   input logic rst_i,
   mmio_dev_if.dev dev,
   output mmio_pkg::dword_t mtime_o,
   output mmio_pkg::dword_t mtimecmp_rd_o,
   output logic [num_core-1:0] timer_irq_o
);

   mmio_pkg::dword_t mtime_r;
   mmio_pkg::dword_t [num_core-1:0] mtimecmp_r;
   logic [num_core-1:0] timer_cond;
   logic [irq_pipe_depth-1:0][num_core-1:0] irq_pipe;

   // Free-running unless software loads it
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         mtime_r <= '0;
      else if (dev.wr_v && dev.mtime_sel)
         mtime_r <= dev.wdata;
      else
         mtime_r <= mtime_r + 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         mtimecmp_r <= '1;
      else
      begin
         for (int i = 0; i < num_core; i++)
         begin
            if (dev.wr_v && dev.mtimecmp_sel[i])
               mtimecmp_r[i] <= dev.wdata;
         end
      end
   end

   // Compare and one-hot readback
   always_comb
   begin
      mtimecmp_rd_o = '0;
      for (int i = 0; i < num_core; i++)
      begin
         timer_cond[i] = (mtime_r >= mtimecmp_r[i]);
         if (dev.mtimecmp_sel[i])
            mtimecmp_rd_o = mtimecmp_rd_o | mtimecmp_r[i];
      end
   end

   // Wire delay toward the tiles
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         irq_pipe <= '0;
      else
      begin
         irq_pipe[0] <= timer_cond;
         for (int s = 1; s < irq_pipe_depth; s++)
            irq_pipe[s] <= irq_pipe[s-1];
      end
   end

   assign timer_irq_o = irq_pipe[irq_pipe_depth-1];
   assign mtime_o = mtime_r;

endmodule

// ==== mmio_cmd_decode.sv ====
// Splits a command address into region and core, producing device selects for the enclave
module mmio_cmd_decode
#(
   parameter int num_core = 4
)
(
   input logic cmd_v_i,
   input logic cmd_wr_i,
   input logic resp_ready_i,
   input mmio_pkg::mmio_addr_t cmd_addr_i,
   input mmio_pkg::dword_t cmd_data_i,
   output logic take_o,
   mmio_dev_if.decode dev,
   output mmio_pkg::region_t rd_region_o
);

   localparam int core_idx_width = (num_core > 1) ? $clog2(num_core) : 1;

   mmio_pkg::region_t region;
   logic [core_idx_width-1:0] core_idx;
   logic [num_core-1:0] core_oh;
   logic mipi_hit;
   logic mtimecmp_hit;
   logic plic_hit;

   // Consume only when a response can go out the same cycle
   assign take_o = cmd_v_i & resp_ready_i;

   assign region = cmd_addr_i[mmio_pkg::region_lsb +: mmio_pkg::region_width];
   assign core_idx = cmd_addr_i[mmio_pkg::byte_offset_width +: core_idx_width];
   assign core_oh = num_core'(1) << core_idx;

   assign mipi_hit = take_o && (region == mmio_pkg::region_mipi);
   assign mtimecmp_hit = take_o && (region == mmio_pkg::region_mtimecmp);
   assign plic_hit = take_o && (region == mmio_pkg::region_plic);

   // Per-core regions get a one-hot core select
   assign dev.mipi_sel = mipi_hit ? core_oh : '0;
   assign dev.mtimecmp_sel = mtimecmp_hit ? core_oh : '0;
   assign dev.plic_sel = plic_hit ? core_oh : '0;

   assign dev.mtime_sel = take_o && (region == mmio_pkg::region_mtime);
   assign dev.cfg_sel = take_o && (region == mmio_pkg::region_cfg);

   assign dev.wr_v = take_o & cmd_wr_i;
   assign dev.wdata = cmd_data_i;

   assign rd_region_o = region;

endmodule

// ==== mmio_dev_if.sv ====
// Decoded register selects and write data, driven by the command decoder into each device
interface mmio_dev_if
#(
   parameter int num_core = 4
);

   logic wr_v;
   logic [num_core-1:0] mipi_sel;
   logic [num_core-1:0] mtimecmp_sel;
   logic [num_core-1:0] plic_sel;
   logic mtime_sel;
   logic cfg_sel;
   mmio_pkg::dword_t wdata;

   modport decode
   (
      output wr_v, mipi_sel, mtimecmp_sel, plic_sel, mtime_sel, cfg_sel, wdata
   );

   modport dev
   (
      input wr_v, mipi_sel, mtimecmp_sel, plic_sel, mtime_sel, cfg_sel, wdata
   );

endinterface

// ==== mmio_pkg.sv ====
// Address map, register widths and config payload layout shared by the MMIO enclave
package mmio_pkg;

   localparam int addr_width = 20;
   localparam int dword_width = 64;
   localparam int region_width = 8;

   // Region code sits in the upper address bits
   localparam int region_lsb = 12;

   // Core index starts above the byte offset of a 64-bit register
   localparam int byte_offset_width = 3;

   typedef logic [addr_width-1:0] mmio_addr_t;
   typedef logic [dword_width-1:0] dword_t;
   typedef logic [region_width-1:0] region_t;

   localparam region_t region_cfg = 8'h00;
   localparam region_t region_mipi = 8'h01;
   localparam region_t region_mtimecmp = 8'h02;
   localparam region_t region_mtime = 8'h03;
   localparam region_t region_plic = 8'h04;

   localparam int cfg_addr_width = 16;
   localparam int cfg_data_width = 32;
   localparam int cfg_core_width = 8;

   typedef logic [cfg_addr_width-1:0] cfg_addr_t;
   typedef logic [cfg_data_width-1:0] cfg_data_t;
   typedef logic [cfg_core_width-1:0] cfg_core_t;

   // Config payload fields in the write data
   localparam int cfg_data_lsb = 0;
   localparam int cfg_addr_lsb = 32;
   localparam int cfg_core_lsb = 48;
   localparam cfg_core_t cfg_broadcast = '1;

endpackage
